//--- hw/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// Entries in each byte FIFO, kept a power of two so the pointers wrap
`define UART_FIFO_DEPTH 8

// Bits in one character on the line
`define UART_DATA_BITS 8

// Receiver samples per bit period
`define UART_OVERSAMPLE 16

`endif

//--- hw/uart_cfg_pkg.sv
`include "uart_macros.svh"

package uart_cfg_pkg;

  // Bit period is div + 1 clock cycles
  typedef logic [15:0] baud_div_t;

  // Wide enough to hold 0 up to a full FIFO
  typedef logic [$clog2(`UART_FIFO_DEPTH + 1)-1:0] fifo_level_t;

  // Static settings of the core
  typedef struct packed {
    logic        tx_en;
    logic        rx_en;
    // Second stop bit on transmit only
    logic        two_stop;
    baud_div_t   div;
    // Transmit FIFO reports below this level
    fifo_level_t tx_mark;
    // Receive FIFO reports above this level
    fifo_level_t rx_mark;
  } uart_cfg_t;

endpackage

//--- hw/uart_data_pkg.sv
`include "uart_macros.svh"

package uart_data_pkg;

  typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

  // Level flags of both FIFOs plus the sticky receive errors
  typedef struct packed {
    logic tx_full;
    logic tx_empty;
    logic tx_below_mark;
    logic rx_full;
    logic rx_empty;
    logic rx_above_mark;
    logic rx_overrun;
    logic rx_frame_error;
  } uart_status_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

//--- hw/uart_fifo.sv
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_fifo (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        push,
  input  uart_data_pkg::uart_byte_t   push_data,
  output logic                        push_ready,
  input  logic                        pop,
  output uart_data_pkg::uart_byte_t   pop_data,
  output logic                        pop_valid,
  input  uart_cfg_pkg::fifo_level_t   mark,
  output uart_cfg_pkg::fifo_level_t   count,
  output logic                        below_mark,
  output logic                        above_mark
);
  import uart_data_pkg::*;
  import uart_cfg_pkg::*;

  localparam int PTR_W = $clog2(`UART_FIFO_DEPTH);

  uart_byte_t       mem [`UART_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign push_ready = (count != fifo_level_t'(`UART_FIFO_DEPTH));
  assign pop_valid  = (count != '0);
  assign do_push    = push && push_ready;
  assign do_pop     = pop && pop_valid;

  // Head is visible without a read cycle
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Level flags follow the registered count
  assign below_mark = (count < mark);
  assign above_mark = (count > mark);

  a_count_bound : assert property (
    @(posedge clock) disable iff (reset)
    count <= fifo_level_t'(`UART_FIFO_DEPTH)
  ) else $error("FIFO count above depth");

endmodule

//--- hw/uart_baud_gen.sv
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_baud_gen (
  input  logic                    clock,
  input  logic                    reset,
  input  uart_cfg_pkg::baud_div_t div,
  output logic                    bit_tick,
  output logic                    sample_tick
);
  import uart_cfg_pkg::*;

  localparam int OS_SHIFT = $clog2(`UART_OVERSAMPLE);

  baud_div_t div_q;
  baud_div_t sample_div;
  baud_div_t bit_cnt;
  baud_div_t sample_cnt;
  logic      div_change;

  // Oversample period is div / 16 rounded down, plus one
  assign sample_div = div >> OS_SHIFT;
  assign div_change = (div != div_q);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      div_q       <= '0;
      bit_cnt     <= '0;
      sample_cnt  <= '0;
      bit_tick    <= 1'b0;
      sample_tick <= 1'b0;
    end else begin
      div_q <= div;
      // A new divisor restarts both periods from zero
      if (div_change || bit_cnt == div) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      if (div_change || sample_cnt == sample_div) begin
        sample_cnt <= '0;
      end else begin
        sample_cnt <= sample_cnt + 1'b1;
      end
      bit_tick    <= !div_change && (bit_cnt == div);
      sample_tick <= !div_change && (sample_cnt == sample_div);
    end
  end

  // Single-cycle enables whenever the period exceeds one cycle
  a_bit_tick_pulse : assert property (
    @(posedge clock) disable iff (reset)
    (bit_tick && div != '0 && !div_change) |=> !bit_tick
  ) else $error("bit_tick held high");

  a_sample_tick_pulse : assert property (
    @(posedge clock) disable iff (reset)
    (sample_tick && sample_div != '0 && !div_change) |=> !sample_tick
  ) else $error("sample_tick held high");

endmodule

//--- hw/uart_tx.sv
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_tx (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      enable,
  input  logic                      two_stop,
  input  logic                      bit_tick,
  input  uart_data_pkg::uart_byte_t data,
  input  logic                      valid,
  output logic                      ready,
  output logic                      txd
);
  import uart_data_pkg::*;

  localparam int CNT_W = $clog2(`UART_DATA_BITS);

  tx_state_e        state;
  uart_byte_t       shift;
  logic [CNT_W-1:0] bit_cnt;

  // One byte per frame, taken only while idle
  assign ready = (state == TX_IDLE) && enable;

  always_ff @(posedge clock) begin
    if (valid && ready) begin
      shift <= data;
    end else if (bit_tick && (state == TX_DATA || (state == TX_START && !txd))) begin
      shift <= shift >> 1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state   <= TX_IDLE;
      bit_cnt <= '0;
      txd     <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (valid && ready) begin
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_tick) begin
            if (txd) begin
              // Line still idle, start bit begins here
              txd <= 1'b0;
            end else begin
              txd     <= shift[0];
              bit_cnt <= '0;
              state   <= TX_DATA;
            end
          end
        end
        TX_DATA: begin
          if (bit_tick) begin
            if (bit_cnt == CNT_W'(`UART_DATA_BITS - 1)) begin
              txd     <= 1'b1;
              bit_cnt <= '0;
              state   <= TX_STOP;
            end else begin
              txd     <= shift[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        TX_STOP: begin
          // bit_cnt marks the first stop bit already done
          if (bit_tick) begin
            if (two_stop && bit_cnt == '0) begin
              bit_cnt <= CNT_W'(1);
            end else begin
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

endmodule

//--- hw/uart_rx.sv
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_rx (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      enable,
  input  logic                      sample_tick,
  input  logic                      rxd,
  output uart_data_pkg::uart_byte_t data,
  output logic                      valid,
  output logic                      frame_error
);
  import uart_data_pkg::*;

  localparam int SMP_W = $clog2(`UART_OVERSAMPLE);
  localparam int CNT_W = $clog2(`UART_DATA_BITS);
  localparam logic [SMP_W-1:0] MID_SAMPLE  = SMP_W'(`UART_OVERSAMPLE / 2 - 1);
  localparam logic [SMP_W-1:0] LAST_SAMPLE = SMP_W'(`UART_OVERSAMPLE - 1);

  rx_state_e        state;
  logic [1:0]       rxd_sync;
  logic             rxd_s;
  logic [SMP_W-1:0] smp_cnt;
  logic [CNT_W-1:0] bit_cnt;
  uart_byte_t       shift;

  assign rxd_s = rxd_sync[1];
  assign data  = shift;

  // Line comes from outside the clock domain
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rxd_sync <= 2'b11;
    end else begin
      rxd_sync <= {rxd_sync[0], rxd};
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clock) begin
    if (state == RX_DATA && sample_tick && smp_cnt == LAST_SAMPLE) begin
      shift <= {rxd_s, shift[`UART_DATA_BITS-1:1]};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state       <= RX_IDLE;
      smp_cnt     <= '0;
      bit_cnt     <= '0;
      valid       <= 1'b0;
      frame_error <= 1'b0;
    end else begin
      valid       <= 1'b0;
      frame_error <= 1'b0;
      case (state)
        RX_IDLE: begin
          smp_cnt <= '0;
          if (enable && !rxd_s) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (sample_tick) begin
            if (smp_cnt == MID_SAMPLE) begin
              // A glitch is high again by mid-bit
              smp_cnt <= '0;
              bit_cnt <= '0;
              state   <= rxd_s ? RX_IDLE : RX_DATA;
            end else begin
              smp_cnt <= smp_cnt + 1'b1;
            end
          end
        end
        RX_DATA: begin
          if (sample_tick) begin
            smp_cnt <= smp_cnt + 1'b1;
            if (smp_cnt == LAST_SAMPLE) begin
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == CNT_W'(`UART_DATA_BITS - 1)) begin
                state <= RX_STOP;
              end
            end
          end
        end
        RX_STOP: begin
          if (sample_tick) begin
            smp_cnt <= smp_cnt + 1'b1;
            if (smp_cnt == LAST_SAMPLE) begin
              valid       <= rxd_s;
              frame_error <= !rxd_s;
              state       <= RX_IDLE;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

//--- hw/uart_phy.sv
`timescale 1ns/1ps

`include "uart_macros.svh"

module uart_phy (
  input  logic                        clock,
  input  logic                        reset,
  input  uart_cfg_pkg::uart_cfg_t     cfg,
  input  uart_data_pkg::uart_byte_t   tx_data,
  input  logic                        tx_valid,
  output logic                        tx_ready,
  output uart_data_pkg::uart_byte_t   rx_data,
  output logic                        rx_valid,
  input  logic                        rx_ready,
  output uart_data_pkg::uart_status_t status,
  output logic                        txd,
  input  logic                        rxd
);
  import uart_cfg_pkg::*;
  import uart_data_pkg::*;

  uart_byte_t  tx_head;
  logic        tx_head_valid;
  logic        tx_ser_ready;
  logic        tx_below;
  fifo_level_t tx_count;
  uart_byte_t  rx_byte;
  logic        rx_byte_valid;
  logic        rx_push_ready;
  logic        rx_frame_pulse;
  logic        rx_above;
  fifo_level_t rx_count;
  logic        bit_tick;
  logic        sample_tick;
  logic        overrun_q;
  logic        frame_err_q;

  uart_fifo u_tx_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (tx_valid),
    .push_data  (tx_data),
    .push_ready (tx_ready),
    .pop        (tx_ser_ready),
    .pop_data   (tx_head),
    .pop_valid  (tx_head_valid),
    .mark       (cfg.tx_mark),
    .count      (tx_count),
    .below_mark (tx_below),
    .above_mark ()
  );

  uart_fifo u_rx_fifo (
    .clock      (clock),
    .reset      (reset),
    .push       (rx_byte_valid),
    .push_data  (rx_byte),
    .push_ready (rx_push_ready),
    .pop        (rx_ready),
    .pop_data   (rx_data),
    .pop_valid  (rx_valid),
    .mark       (cfg.rx_mark),
    .count      (rx_count),
    .below_mark (),
    .above_mark (rx_above)
  );

  uart_baud_gen u_baud_gen (
    .clock       (clock),
    .reset       (reset),
    .div         (cfg.div),
    .bit_tick    (bit_tick),
    .sample_tick (sample_tick)
  );

  // Pop happens on the same edge the serializer takes the head
  uart_tx u_tx (
    .clock    (clock),
    .reset    (reset),
    .enable   (cfg.tx_en),
    .two_stop (cfg.two_stop),
    .bit_tick (bit_tick),
    .data     (tx_head),
    .valid    (tx_head_valid),
    .ready    (tx_ser_ready),
    .txd      (txd)
  );

  uart_rx u_rx (
    .clock       (clock),
    .reset       (reset),
    .enable      (cfg.rx_en),
    .sample_tick (sample_tick),
    .rxd         (rxd),
    .data        (rx_byte),
    .valid       (rx_byte_valid),
    .frame_error (rx_frame_pulse)
  );

  // Errors stay set until reset
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      overrun_q   <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      if (rx_byte_valid && !rx_push_ready) begin
        overrun_q <= 1'b1;
      end
      if (rx_frame_pulse) begin
        frame_err_q <= 1'b1;
      end
    end
  end

  assign status.tx_full        = (tx_count == fifo_level_t'(`UART_FIFO_DEPTH));
  assign status.tx_empty       = (tx_count == '0);
  assign status.tx_below_mark  = tx_below;
  assign status.rx_full        = (rx_count == fifo_level_t'(`UART_FIFO_DEPTH));
  assign status.rx_empty       = (rx_count == '0);
  assign status.rx_above_mark  = rx_above;
  assign status.rx_overrun     = overrun_q;
  assign status.rx_frame_error = frame_err_q;

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock <= 1'b0;
    forever begin
      #(PERIOD_NS / 2) clock <= ~clock;
    end
  end

  // Released on a rising edge so the first active cycle is a full one
  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- testbench/tb_uart_phy.sv
`timescale 1ns/1ps

`include "uart_macros.svh"

module tb_uart_phy;
  import uart_cfg_pkg::*;
  import uart_data_pkg::*;

  localparam int DIV             = 31;
  localparam int BIT_CYCLES      = DIV + 1;
  localparam int FRAME_CYCLES    = 11 * BIT_CYCLES;
  localparam int TOTAL_BYTES     = 68;
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 40 * FRAME_CYCLES + 2000;
  localparam int DEPTH           = `UART_FIFO_DEPTH;

  logic         clock;
  logic         reset;
  uart_cfg_t    cfg;
  uart_byte_t   tx_data;
  logic         tx_valid;
  logic         tx_ready;
  uart_byte_t   rx_data;
  logic         rx_valid;
  logic         rx_ready;
  uart_status_t status;
  logic         txd;
  logic         rxd_line;
  logic         drive_en;
  logic         drv_line;

  logic [15:0]  lfsr_state     = 16'd80;
  uart_byte_t   exp_q[$];
  uart_byte_t   line_q[$];
  uart_byte_t   rx_expected;
  int           frames_done    = 0;
  int           error_count    = 0;
  logic         overrun_seen   = 1'b0;
  logic         frame_err_seen = 1'b0;

  tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(16)) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  uart_phy u_dut (
    .clock    (clock),
    .reset    (reset),
    .cfg      (cfg),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .rx_data  (rx_data),
    .rx_valid (rx_valid),
    .rx_ready (rx_ready),
    .status   (status),
    .txd      (txd),
    .rxd      (rxd_line)
  );

  // Loopback unless the serial driver owns the line
  assign rxd_line = drive_en ? drv_line : txd;

  task automatic fail_run(input string msg);
    error_count++;
    $display("FAILED at %0d ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_byte(input uart_byte_t actual, input uart_byte_t expected,
                            input string what);
    if (actual !== expected) begin
      fail_run($sformatf("%s: got 0x%02h, expected 0x%02h", what, actual, expected));
    end
  endtask

  task automatic check_status(input uart_status_t actual, input uart_status_t expected,
                              input string what);
    if (actual !== expected) begin
      fail_run($sformatf("%s: status got %b, expected %b", what, actual, expected));
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_byte(output uart_byte_t b);
    for (int i = 0; i < `UART_DATA_BITS; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b[i] = lfsr_state[0];
    end
  endtask

  // Line level in each bit period: start, data LSB first, stop bits
  function automatic logic [10:0] uart_frame_model(input uart_byte_t b, input logic two_stop,
                                                   output int nbits);
    logic [10:0] levels;
    levels[0]   = 1'b0;
    levels[8:1] = b;
    levels[9]   = 1'b1;
    levels[10]  = 1'b1;
    nbits = two_stop ? 11 : 10;
    return levels;
  endfunction

  function automatic uart_status_t expect_status(input int tx_n, input int rx_n);
    uart_status_t s;
    s.tx_full        = (tx_n == DEPTH);
    s.tx_empty       = (tx_n == 0);
    s.tx_below_mark  = (tx_n < int'(cfg.tx_mark));
    s.rx_full        = (rx_n == DEPTH);
    s.rx_empty       = (rx_n == 0);
    s.rx_above_mark  = (rx_n > int'(cfg.rx_mark));
    s.rx_overrun     = overrun_seen;
    s.rx_frame_error = frame_err_seen;
    return s;
  endfunction

  task automatic write_byte(input uart_byte_t b);
    logic done;
    done = 1'b0;
    @(posedge clock);
    tx_data  <= b;
    tx_valid <= 1'b1;
    while (!done) begin
      @(negedge clock);
      done = tx_ready;
      @(posedge clock);
    end
    tx_valid <= 1'b0;
  endtask

  task automatic wait_frames(input int target);
    while (frames_done < target) begin
      @(negedge clock);
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || line_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (2 * BIT_CYCLES) @(negedge clock);
  endtask

  task automatic run_loopback(input int n);
    uart_byte_t b;
    for (int i = 0; i < n; i++) begin
      random_byte(b);
      exp_q.push_back(b);
      line_q.push_back(b);
      write_byte(b);
    end
    wait_drain();
    check_status(status, expect_status(0, 0), "after loopback");
  endtask

  task automatic drive_frame(input uart_byte_t b, input logic stop_ok);
    logic [10:0] levels;
    int          nbits;
    int          hold;
    levels = uart_frame_model(b, 1'b0, nbits);
    for (int i = 0; i < nbits; i++) begin
      hold = BIT_CYCLES;
      // Bad stop bit ends early so the false start after it is rejected
      if (i == nbits - 1 && !stop_ok) begin
        hold = BIT_CYCLES * 3 / 4;
      end
      @(posedge clock);
      drv_line <= (i == nbits - 1) ? stop_ok : levels[i];
      repeat (hold - 1) @(posedge clock);
    end
    @(posedge clock);
    drv_line <= 1'b1;
    repeat (2 * BIT_CYCLES) @(posedge clock);
  endtask

  // Received bytes in write order
  always @(negedge clock) begin
    if (reset === 1'b0 && rx_valid && rx_ready) begin
      if (exp_q.size() == 0) begin
        fail_run($sformatf("received byte 0x%02h with none expected", rx_data));
      end else begin
        rx_expected = exp_q.pop_front();
        check_byte(rx_data, rx_expected, "received byte");
      end
    end
  end

  initial begin : line_monitor
    logic [10:0] levels;
    int          nbits;
    uart_byte_t  frame_byte;
    forever begin
      @(negedge clock);
      if (reset === 1'b0 && txd === 1'b0) begin
        if (line_q.size() == 0) begin
          fail_run("start bit on txd with no byte written");
        end else begin
          frame_byte = line_q[0];
          levels = uart_frame_model(frame_byte, cfg.two_stop, nbits);
          // From the first cycle of the start bit to its middle
          repeat (BIT_CYCLES / 2) @(negedge clock);
          for (int i = 0; i < nbits; i++) begin
            if (i > 0) begin
              repeat (BIT_CYCLES) @(negedge clock);
            end
            if (txd !== levels[i]) begin
              fail_run($sformatf("txd bit %0d of frame 0x%02h: got %b, expected %b",
                                 i, frame_byte, txd, levels[i]));
            end
          end
          void'(line_q.pop_front());
          frames_done++;
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : main_sequence
    uart_byte_t b;
    int         base;
    cfg      <= '{tx_en: 1'b1, rx_en: 1'b1, two_stop: 1'b0, div: baud_div_t'(DIV),
                  tx_mark: fifo_level_t'(5), rx_mark: fifo_level_t'(5)};
    tx_data  <= '0;
    tx_valid <= 1'b0;
    rx_ready <= 1'b1;
    drive_en <= 1'b0;
    drv_line <= 1'b1;
    @(negedge reset);
    @(negedge clock);
    if (txd !== 1'b1) fail_run("txd not idle high after reset");
    if (tx_ready !== 1'b1) fail_run("tx_ready low after reset");
    if (rx_valid !== 1'b0) fail_run("rx_valid high after reset");
    check_status(status, expect_status(0, 0), "after reset");

    // Loopback with one and then two stop bits
    run_loopback(24);
    @(posedge clock);
    cfg.two_stop <= 1'b1;
    run_loopback(24);
    @(posedge clock);
    cfg.two_stop <= 1'b0;

    // Transmit FIFO fills while the serializer is held off
    @(posedge clock);
    cfg.tx_en <= 1'b0;
    for (int k = 1; k <= DEPTH; k++) begin
      random_byte(b);
      exp_q.push_back(b);
      line_q.push_back(b);
      write_byte(b);
      @(negedge clock);
      check_status(status, expect_status(k, 0), "filling transmit FIFO");
    end
    if (tx_ready !== 1'b0) fail_run("tx_ready high with a full transmit FIFO");
    @(posedge clock);
    cfg.tx_en <= 1'b1;
    wait_drain();
    check_status(status, expect_status(0, 0), "after transmit back-pressure");

    // Receive FIFO fills with the host not reading, last two bytes lost
    @(posedge clock);
    rx_ready <= 1'b0;
    base = frames_done;
    for (int k = 1; k <= DEPTH + 2; k++) begin
      random_byte(b);
      line_q.push_back(b);
      if (k <= DEPTH) begin
        exp_q.push_back(b);
      end
      write_byte(b);
      wait_frames(base + k);
      repeat (8) @(negedge clock);
      if (k > DEPTH) begin
        overrun_seen = 1'b1;
      end
      check_status(status, expect_status(0, (k > DEPTH) ? DEPTH : k), "filling receive FIFO");
    end
    @(posedge clock);
    rx_ready <= 1'b1;
    wait_drain();
    check_status(status, expect_status(0, 0), "after receive overrun");

    // Low stop bit from the serial driver, then a good frame
    @(posedge clock);
    drive_en <= 1'b1;
    random_byte(b);
    drive_frame(b, 1'b0);
    @(negedge clock);
    frame_err_seen = 1'b1;
    check_status(status, expect_status(0, 0), "after bad stop bit");
    random_byte(b);
    exp_q.push_back(b);
    drive_frame(b, 1'b1);
    wait_drain();
    check_status(status, expect_status(0, 0), "after good frame");

    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- uart_core.f
+incdir+hw
hw/uart_cfg_pkg.sv
hw/uart_data_pkg.sv
hw/uart_fifo.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_phy.sv
testbench/tb_clock_gen.sv
testbench/tb_uart_phy.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the uart_phy testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_uart_phy \
  -f uart_core.f \
  -o tb_uart_phy

./obj_dir/tb_uart_phy > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "Simulation failed"
  exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

echo "Simulation passed"
